// File: src/mac_sideband_cfg.svh
//--------------------------------------
// mac sideband widths
// statistics vector, pause quanta and pause frame sizes
//--------------------------------------

`ifndef MAC_SIDEBAND_CFG_SVH
`define MAC_SIDEBAND_CFG_SVH

//--------------------------------------
// statistics vectors
//--------------------------------------

// receive statistics vector from the mac core
`define RX_STATS_W 28

// transmit statistics vector from the mac core
`define TX_STATS_W 32

//--------------------------------------
// pause interface
//--------------------------------------

// pause quanta carried by one serial pause word
`define PAUSE_QUANTA_W 16

// serial pause history length
// one leading zero, start bit, quanta, stop bit
// 19 bits for a 16 bit quanta
`define PAUSE_FRAME_W (`PAUSE_QUANTA_W + 3)

`endif

// File: src/mac_sideband_pkg.sv
//--------------------------------------
// mac sideband types
// statistics vectors and pause control shared by rtl and testbench
//--------------------------------------

`include "mac_sideband_cfg.svh"

package mac_sideband_pkg;

  //--------------------------------------
  // statistics vectors
  //--------------------------------------

  // receive statistics as handed over by the mac
  // with its valid strobe
  // sent out msb first on rx_statistics_s
  typedef logic [`RX_STATS_W-1:0] rx_stats_vec_t;

  // transmit statistics, same handling as receive
  // only wider
  // sent out msb first on tx_statistics_s
  typedef logic [`TX_STATS_W-1:0] tx_stats_vec_t;

  //--------------------------------------
  // pause control
  //--------------------------------------

  // pause quanta in units of 512 bit times
  // as seen by the mac pause logic
  typedef logic [`PAUSE_QUANTA_W-1:0] pause_quanta_t;

  // pause request towards the mac
  // req is a one cycle pulse
  // val holds the quanta in the req cycle
  // and is zero otherwise
  typedef struct packed {
    logic          req;
    pause_quanta_t val;
  } pause_ctrl_t;

endpackage

// File: src/stats_serializer.sv
//--------------------------------------
// statistics serialiser
// framed one wire copy of a statistics vector, msb first
//--------------------------------------

`timescale 1ns/10ps

module stats_serializer #(
  // payload carried by one frame
  // any packed type, width taken from its bits
  parameter type vec_t = logic [7:0]
) (
  input  logic gtx_clk_bufg,
  input  logic rst_n,

  // statistics strobe and vector
  // vector only sampled on a rising edge of valid
  input  logic valid,
  input  vec_t vector,

  // serial stream
  // start bit, vector msb first, stop bit, then zeros
  output logic serial
);

  //--------------------------------------
  // frame geometry
  //--------------------------------------

  // payload bits
  localparam int VEC_W = $bits(vec_t);

  // start bit + payload + stop bit
  localparam int FRAME_W = VEC_W + 2;

  //--------------------------------------
  // signals
  //--------------------------------------

  // valid from the previous cycle
  logic valid_q;

  // one cycle high on the first cycle of valid
  logic valid_rise;

  // vector as plain bits for framing
  logic [VEC_W-1:0] vec_bits;

  // frame in flight, top bit is on the wire
  logic [FRAME_W-1:0] shift_q;

  // next shifter contents
  logic [FRAME_W-1:0] shift_d;

  //--------------------------------------
  // valid edge detect
  //--------------------------------------

  // held valid gives one load only
  always_ff @(posedge gtx_clk_bufg or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= valid;
    end
  end

  assign valid_rise = valid & ~valid_q;

  //--------------------------------------
  // shifter
  //--------------------------------------

  assign vec_bits = vector;

  // load on a rising edge
  // a new edge mid frame simply restarts the frame
  always_comb begin
    if (valid_rise) begin
      shift_d = {1'b1, vec_bits, 1'b1};
    end else begin
      // free running, zero fill behind the frame
      shift_d = {shift_q[FRAME_W-2:0], 1'b0};
    end
  end

  // shifter always runs
  // idle line stays low once the stop bit has left
  always_ff @(posedge gtx_clk_bufg or negedge rst_n) begin
    if (!rst_n) begin
      shift_q <= '0;
    end else begin
      shift_q <= shift_d;
    end
  end

  // start bit shows up the cycle after the sampling edge
  assign serial = shift_q[FRAME_W-1];

endmodule

// File: src/pause_deframer.sv
//--------------------------------------
// pause deframer
// serial pause word to a one cycle pause request with quanta
//--------------------------------------

`timescale 1ns/10ps

`include "mac_sideband_cfg.svh"

module pause_deframer (
  input  logic gtx_clk_bufg,
  input  logic rst_n,

  // serial pause line
  // idle zeros, start bit 1, quanta msb first, stop bit 1
  input  logic pause_req_s,

  // registered pause request towards the mac
  output mac_sideband_pkg::pause_ctrl_t pause_ctrl
);

  //--------------------------------------
  // history layout
  //--------------------------------------

  // history length, oldest bit at the top
  localparam int HIST_W = `PAUSE_FRAME_W;

  // quanta width
  localparam int QUANTA_W = `PAUSE_QUANTA_W;

  // bit positions inside the history
  // stop bit is the newest sample at bit 0
  // quanta sits just above it
  localparam int STOP_POS  = 0;
  localparam int START_POS = QUANTA_W + 1;
  localparam int ZERO_POS  = HIST_W - 1;

  //--------------------------------------
  // signals
  //--------------------------------------

  // last HIST_W samples of the serial line
  logic [HIST_W-1:0] hist_q;

  // zero, start and stop in place
  logic frame_match;

  // next pause_ctrl value
  mac_sideband_pkg::pause_ctrl_t ctrl_d;

  //--------------------------------------
  // serial history
  //--------------------------------------

  // newest sample enters at the low end
  always_ff @(posedge gtx_clk_bufg or negedge rst_n) begin
    if (!rst_n) begin
      hist_q <= '0;
    end else begin
      hist_q <= {hist_q[HIST_W-2:0], pause_req_s};
    end
  end

  //--------------------------------------
  // alignment test
  //--------------------------------------

  // leading zero keeps a long run of ones from matching twice
  // misaligned hits inside data are not filtered
  assign frame_match = ~hist_q[ZERO_POS] & hist_q[START_POS] & hist_q[STOP_POS];

  // quanta between start and stop, cleared when no match
  always_comb begin
    ctrl_d = '0;
    if (frame_match) begin
      ctrl_d.req = 1'b1;
      ctrl_d.val = hist_q[START_POS-1:STOP_POS+1];
    end
  end

  //--------------------------------------
  // output register
  //--------------------------------------

  // req is high for one cycle per aligned word
  always_ff @(posedge gtx_clk_bufg or negedge rst_n) begin
    if (!rst_n) begin
      pause_ctrl <= '0;
    end else begin
      pause_ctrl <= ctrl_d;
    end
  end

endmodule

// File: src/mac_sideband_top.sv
//--------------------------------------
// mac sideband top
// rx and tx statistics serialisers, pause deframer
//--------------------------------------

`timescale 1ns/10ps

module mac_sideband_top (
  input  logic gtx_clk_bufg,
  input  logic rst_n,

  //--------------------------------------
  // statistics from the mac
  //--------------------------------------

  // receive statistics strobe and vector
  input  logic                           rx_statistics_valid,
  input  mac_sideband_pkg::rx_stats_vec_t rx_statistics_vector,

  // transmit statistics strobe and vector
  input  logic                           tx_statistics_valid,
  input  mac_sideband_pkg::tx_stats_vec_t tx_statistics_vector,

  //--------------------------------------
  // serial pause input
  //--------------------------------------

  input  logic                           pause_req_s,

  //--------------------------------------
  // serial statistics outputs
  //--------------------------------------

  // 30 cycle frames
  output logic                           rx_statistics_s,

  // 34 cycle frames
  output logic                           tx_statistics_s,

  //--------------------------------------
  // pause request towards the mac
  //--------------------------------------

  output mac_sideband_pkg::pause_ctrl_t  pause_ctrl
);

  //--------------------------------------
  // receive statistics
  //--------------------------------------

  // frame width follows rx_stats_vec_t
  stats_serializer #(
    .vec_t (mac_sideband_pkg::rx_stats_vec_t)
  ) i_rx_stats_ser (
    .gtx_clk_bufg (gtx_clk_bufg),
    .rst_n        (rst_n),
    .valid        (rx_statistics_valid),
    .vector       (rx_statistics_vector),
    .serial       (rx_statistics_s)
  );

  //--------------------------------------
  // transmit statistics
  //--------------------------------------

  // runs independently of the receive side
  // both may be mid frame together
  stats_serializer #(
    .vec_t (mac_sideband_pkg::tx_stats_vec_t)
  ) i_tx_stats_ser (
    .gtx_clk_bufg (gtx_clk_bufg),
    .rst_n        (rst_n),
    .valid        (tx_statistics_valid),
    .vector       (tx_statistics_vector),
    .serial       (tx_statistics_s)
  );

  //--------------------------------------
  // pause deframing
  //--------------------------------------

  // request pulse plus quanta, no handshake back
  pause_deframer i_pause_deframer (
    .gtx_clk_bufg (gtx_clk_bufg),
    .rst_n        (rst_n),
    .pause_req_s  (pause_req_s),
    .pause_ctrl   (pause_ctrl)
  );

endmodule

// File: verif/mac_sideband_props.sv
//--------------------------------------
// mac sideband properties
// pause pulse shape and serial start bits
//--------------------------------------

`timescale 1ns/10ps

module mac_sideband_props (
  input logic                          gtx_clk_bufg,
  input logic                          rst_n,
  input logic                          rx_statistics_valid,
  input logic                          tx_statistics_valid,
  input logic                          rx_statistics_s,
  input logic                          tx_statistics_s,
  input mac_sideband_pkg::pause_ctrl_t pause_ctrl
);

  // quanta only present with a request
  a_val_idle_zero: assert property (@(posedge gtx_clk_bufg) disable iff (!rst_n)
    !pause_ctrl.req |-> pause_ctrl.val == '0)
    else $error("pause quanta nonzero without a request");

  // request is a single cycle pulse
  a_req_pulse: assert property (@(posedge gtx_clk_bufg) disable iff (!rst_n)
    pause_ctrl.req |=> !pause_ctrl.req)
    else $error("pause request held for two cycles");

  // start bit follows each valid edge
  a_rx_start: assert property (@(posedge gtx_clk_bufg) disable iff (!rst_n)
    $rose(rx_statistics_valid) |=> rx_statistics_s)
    else $error("rx start bit missing after valid edge");

  a_tx_start: assert property (@(posedge gtx_clk_bufg) disable iff (!rst_n)
    $rose(tx_statistics_valid) |=> tx_statistics_s)
    else $error("tx start bit missing after valid edge");

endmodule

bind mac_sideband_top mac_sideband_props i_props (.*);

// File: verif/tb_mac_sideband.sv
//--------------------------------------
// mac sideband testbench
// random stats frames and pause words against a reference model
//--------------------------------------

`timescale 1ns/10ps

`include "mac_sideband_cfg.svh"

module tb_mac_sideband;

  //--------------------------------------
  // cycle budget per test
  //--------------------------------------

  localparam int RESET_CYC   = 8;
  localparam int RX_CYC      = 40;
  localparam int TX_CYC      = 50;
  localparam int RESTART_CYC = 90;
  localparam int PAUSE_N     = 8;
  localparam int PAUSE_CYC   = PAUSE_N * 40;
  localparam int RAND_CYC    = 400;
  localparam int TAIL_CYC    = 40;
  localparam int TOTAL_CYC   = RESET_CYC + RX_CYC + TX_CYC + RESTART_CYC
                             + PAUSE_CYC + RAND_CYC + TAIL_CYC;
  // 4 ns period, twice the budget as margin
  localparam int TIMEOUT_NS  = TOTAL_CYC * 4 * 2;

  // clock low from time zero, first falling edge at 4 ns
  logic                            gtx_clk_bufg = 1'b0;
  logic                            rst_n;
  logic                            rx_statistics_valid;
  mac_sideband_pkg::rx_stats_vec_t rx_statistics_vector;
  logic                            tx_statistics_valid;
  mac_sideband_pkg::tx_stats_vec_t tx_statistics_vector;
  logic                            pause_req_s;
  logic                            rx_statistics_s;
  logic                            tx_statistics_s;
  mac_sideband_pkg::pause_ctrl_t   pause_ctrl;

  integer seed = 32'h8175_419e;
  int     err_cnt = 0;
  int     chk_cnt = 0;

  // model state, top bit of each stream is the expected wire
  logic [63:0]                   rx_stream;
  logic [63:0]                   tx_stream;
  logic                          rx_valid_prev;
  logic                          tx_valid_prev;
  logic [`PAUSE_FRAME_W-1:0]     pause_hist;
  mac_sideband_pkg::pause_ctrl_t exp_ctrl;

  mac_sideband_top i_dut (
    .gtx_clk_bufg         (gtx_clk_bufg),
    .rst_n                (rst_n),
    .rx_statistics_valid  (rx_statistics_valid),
    .rx_statistics_vector (rx_statistics_vector),
    .tx_statistics_valid  (tx_statistics_valid),
    .tx_statistics_vector (tx_statistics_vector),
    .pause_req_s          (pause_req_s),
    .rx_statistics_s      (rx_statistics_s),
    .tx_statistics_s      (tx_statistics_s),
    .pause_ctrl           (pause_ctrl)
  );

  always #2 gtx_clk_bufg = ~gtx_clk_bufg;

  //--------------------------------------
  // reference functions
  //--------------------------------------

  // start bit, vector msb first, stop bit, left aligned
  function automatic logic [63:0] stats_frame(input logic [63:0] vec, input int width);
    logic [63:0] stream;
    stream = '0;
    stream[63] = 1'b1;
    for (int i = 0; i < width; i++) begin
      stream[62-i] = vec[width-1-i];
    end
    stream[62-width] = 1'b1;
    return stream;
  endfunction

  // oldest bit zero, next one start, newest one stop
  function automatic mac_sideband_pkg::pause_ctrl_t pause_expect(
    input logic [`PAUSE_FRAME_W-1:0] hist
  );
    mac_sideband_pkg::pause_ctrl_t ctrl;
    ctrl = '0;
    if (!hist[`PAUSE_FRAME_W-1] && hist[`PAUSE_FRAME_W-2] && hist[0]) begin
      ctrl.req = 1'b1;
      ctrl.val = hist[`PAUSE_FRAME_W-3:1];
    end
    return ctrl;
  endfunction

  //--------------------------------------
  // model and comparison
  //--------------------------------------

  // model steps on the same edge as the dut
  always @(posedge gtx_clk_bufg or negedge rst_n) begin
    if (!rst_n) begin
      rx_stream = '0;
      tx_stream = '0;
      rx_valid_prev = 1'b0;
      tx_valid_prev = 1'b0;
      pause_hist = '0;
      exp_ctrl = '0;
    end else begin
      if (rx_statistics_valid && !rx_valid_prev) begin
        rx_stream = stats_frame(rx_statistics_vector, `RX_STATS_W);
      end else begin
        rx_stream = rx_stream << 1;
      end
      if (tx_statistics_valid && !tx_valid_prev) begin
        tx_stream = stats_frame(tx_statistics_vector, `TX_STATS_W);
      end else begin
        tx_stream = tx_stream << 1;
      end
      rx_valid_prev = rx_statistics_valid;
      tx_valid_prev = tx_statistics_valid;
      // registered output sees the history before this edge
      exp_ctrl = pause_expect(pause_hist);
      pause_hist = {pause_hist[`PAUSE_FRAME_W-2:0], pause_req_s};
    end
  end

  // outputs settled half a cycle after the edge
  always @(negedge gtx_clk_bufg) begin
    chk_cnt++;
    assert (rx_statistics_s === rx_stream[63]) else begin
      $display("Error at %0t: rx_statistics_s expected %0b got %0b",
               $time, rx_stream[63], rx_statistics_s);
      err_cnt++;
    end
    assert (tx_statistics_s === tx_stream[63]) else begin
      $display("Error at %0t: tx_statistics_s expected %0b got %0b",
               $time, tx_stream[63], tx_statistics_s);
      err_cnt++;
    end
    assert (pause_ctrl === exp_ctrl) else begin
      $display("Error at %0t: pause_ctrl expected %h got %h", $time, exp_ctrl, pause_ctrl);
      err_cnt++;
    end
  end

  //--------------------------------------
  // stimulus helpers
  //--------------------------------------

  // inputs change 1 ns after the rising edge
  task automatic next_cycle(input int n = 1);
    repeat (n) @(posedge gtx_clk_bufg);
    #1;
  endtask

  // aligned word, then wait for its request pulse
  task automatic send_pause(input mac_sideband_pkg::pause_quanta_t quanta);
    int wait_cyc;
    pause_req_s = 1'b1;
    next_cycle();
    for (int i = `PAUSE_QUANTA_W - 1; i >= 0; i--) begin
      pause_req_s = quanta[i];
      next_cycle();
    end
    pause_req_s = 1'b1;
    next_cycle();
    pause_req_s = 1'b0;
    wait_cyc = 0;
    while (pause_ctrl.req !== 1'b1 && wait_cyc < 4) begin
      next_cycle();
      wait_cyc++;
    end
    assert (pause_ctrl.req === 1'b1) else begin
      $display("no pause request seen after an aligned pause frame at %0t", $time);
      err_cnt++;
    end
    assert (pause_ctrl.val === quanta) else begin
      $display("Error at %0t: pause_ctrl.val expected %h got %h", $time, quanta, pause_ctrl.val);
      err_cnt++;
    end
    // idle zeros between words
    next_cycle(2 + ($random(seed) & 32'h3));
  endtask

  //--------------------------------------
  // test sequence
  //--------------------------------------

  initial begin
    rst_n = 1'b0;
    rx_statistics_valid = 1'b0;
    rx_statistics_vector = '0;
    tx_statistics_valid = 1'b0;
    tx_statistics_vector = '0;
    pause_req_s = 1'b0;
    // reset state, all inputs low
    repeat (4) @(posedge gtx_clk_bufg);
    #1;
    rst_n = 1'b1;
    next_cycle(4);

    // single receive frame
    rx_statistics_vector = $random(seed);
    rx_statistics_valid = 1'b1;
    next_cycle();
    rx_statistics_valid = 1'b0;
    next_cycle(RX_CYC);

    // tx valid held high, rx frame alongside
    tx_statistics_vector = $random(seed);
    tx_statistics_valid = 1'b1;
    rx_statistics_vector = $random(seed);
    rx_statistics_valid = 1'b1;
    next_cycle();
    rx_statistics_valid = 1'b0;
    // new vector under a held valid must not load
    tx_statistics_vector = $random(seed);
    next_cycle(4);
    tx_statistics_valid = 1'b0;
    next_cycle(TX_CYC - 5);

    // restart both serialisers mid frame
    rx_statistics_vector = $random(seed);
    rx_statistics_valid = 1'b1;
    next_cycle();
    rx_statistics_valid = 1'b0;
    next_cycle(12);
    rx_statistics_vector = $random(seed);
    rx_statistics_valid = 1'b1;
    tx_statistics_vector = $random(seed);
    tx_statistics_valid = 1'b1;
    next_cycle();
    rx_statistics_valid = 1'b0;
    tx_statistics_valid = 1'b0;
    next_cycle(15);
    tx_statistics_vector = $random(seed);
    tx_statistics_valid = 1'b1;
    next_cycle();
    tx_statistics_valid = 1'b0;
    next_cycle(RESTART_CYC - 30);

    // aligned pause words
    for (int n = 0; n < PAUSE_N; n++) begin
      send_pause($random(seed));
    end

    // random serial line and sparse valid strobes
    for (int i = 0; i < RAND_CYC; i++) begin
      pause_req_s = $random(seed);
      rx_statistics_vector = $random(seed);
      tx_statistics_vector = $random(seed);
      rx_statistics_valid = ($random(seed) & 32'hf) == 0;
      tx_statistics_valid = ($random(seed) & 32'hf) == 0;
      next_cycle();
    end
    pause_req_s = 1'b0;
    rx_statistics_valid = 1'b0;
    tx_statistics_valid = 1'b0;
    next_cycle(TAIL_CYC);

    $display("checks: %0d, errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("timeout: tests did not complete within %0d ns", TIMEOUT_NS);
    $display("Testbench failed");
    $finish;
  end

endmodule

// File: src.f
+incdir+src
src/mac_sideband_pkg.sv
src/stats_serializer.sv
src/pause_deframer.sv
src/mac_sideband_top.sv
verif/mac_sideband_props.sv
verif/tb_mac_sideband.sv
